/* verilog/mat_part_pkg.sv */
`default_nettype none

package mat_part_pkg;

    // requested partition mode, sampled with start
    typedef enum logic [1:0] {
        MODE_2X2  = 2'd0,
        MODE_4X4  = 2'd1,
        MODE_AUTO = 2'd2
    } part_mode_e;

    // tile emitter states
    typedef enum logic [1:0] {
        // waiting for scan_done
        EMIT_IDLE  = 2'd0,
        // issuing one read address per cycle
        EMIT_TILE  = 2'd1,
        // last element still in the data stage
        EMIT_DRAIN = 2'd2,
        // done pulse
        EMIT_DONE  = 2'd3
    } emit_state_e;

    // auto mode picks 2x2 above this sparsity
    localparam int AUTO_SPARSE_PCT = 50;

    // sparsity percentage, 0..100
    localparam int PCT_W = 7;

endpackage

`default_nettype wire

/* verilog/matrix_buffer.sv */
`timescale 1ns/1ns
`default_nettype none

module matrix_buffer #(
    parameter int MAX_DIM    = 8,
    parameter int DATA_WIDTH = 16,
    localparam int DEPTH     = MAX_DIM * MAX_DIM,
    localparam int ADDR_W    = $clog2(DEPTH)
) (
    input  logic                         clk,

    // write side, from the scanner
    input  logic                         wr_en,
    input  logic [ADDR_W-1:0]            wr_addr,
    input  logic signed [DATA_WIDTH-1:0] wr_data,

    // read side, from the emitter
    input  logic [ADDR_W-1:0]            rd_addr,
    output logic signed [DATA_WIDTH-1:0] rd_data
);

    // row * MAX_DIM + col
    logic signed [DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // one cycle read latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

/* verilog/matrix_scanner.sv */
`timescale 1ns/1ns
`default_nettype none

module matrix_scanner #(
    parameter int MAX_DIM    = 8,
    parameter int DATA_WIDTH = 16,
    localparam int DIM_W     = $clog2(MAX_DIM + 1),
    localparam int ADDR_W    = $clog2(MAX_DIM * MAX_DIM)
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // run config and element stream
    input  logic                           start,
    input  logic [DIM_W-1:0]               matrix_dim,
    input  mat_part_pkg::part_mode_e       partition_mode,
    input  logic                           diag_only,
    input  logic signed [DATA_WIDTH-1:0]   elem_data,
    input  logic                           elem_valid,
    input  logic                           emit_done,

    // buffer write port
    output logic                           wr_en,
    output logic [ADDR_W-1:0]              wr_addr,
    output logic signed [DATA_WIDTH-1:0]   wr_data,

    // results for the emitter
    output logic                           scan_done,
    output logic [DIM_W-1:0]               cfg_dim,
    output mat_part_pkg::part_mode_e       cfg_mode,
    output logic                           cfg_diag_only,
    output logic [mat_part_pkg::PCT_W-1:0] sparsity_pct,
    output logic                           diag_dominant,
    output logic                           busy
);
    import mat_part_pkg::*;

    localparam int IDX_W  = $clog2(MAX_DIM);
    localparam int ZCNT_W = $clog2(MAX_DIM * MAX_DIM + 1);
    localparam int REM_W  = $clog2(MAX_DIM * MAX_DIM * 100 + 1);
    localparam int SUM_W  = DATA_WIDTH + $clog2(MAX_DIM * MAX_DIM);

    typedef enum logic [1:0] {
        SCAN_IDLE = 2'd0,
        SCAN_LOAD = 2'd1,
        SCAN_DIV  = 2'd2,
        SCAN_WAIT = 2'd3
    } scan_state_e;

    scan_state_e       state;
    logic [IDX_W-1:0]  row;
    logic [IDX_W-1:0]  col;
    logic [ZCNT_W-1:0] zeros;
    logic [ZCNT_W-1:0] zeros_nxt;
    logic [ZCNT_W-1:0] dim_sq;
    logic [SUM_W-1:0]  diag_sum;
    logic [SUM_W-1:0]  off_sum;
    logic [REM_W-1:0]  rem;
    logic [PCT_W-1:0]  quot;
    logic              row_last;
    logic              col_last;

    function automatic logic [DATA_WIDTH-1:0] abs_val(input logic signed [DATA_WIDTH-1:0] v);
        // -min still fits as unsigned
        return v[DATA_WIDTH-1] ? DATA_WIDTH'(-v) : DATA_WIDTH'(v);
    endfunction

    assign row_last  = (DIM_W'(row) == cfg_dim - 1'b1);
    assign col_last  = (DIM_W'(col) == cfg_dim - 1'b1);
    assign zeros_nxt = zeros + ZCNT_W'(elem_data == '0);
    assign dim_sq    = ZCNT_W'(cfg_dim) * ZCNT_W'(cfg_dim);

    // held from the accepted start until emit_done
    assign busy = (state != SCAN_IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= SCAN_IDLE;
            row           <= '0;
            col           <= '0;
            zeros         <= '0;
            diag_sum      <= '0;
            off_sum       <= '0;
            rem           <= '0;
            quot          <= '0;
            wr_en         <= 1'b0;
            scan_done     <= 1'b0;
            cfg_dim       <= '0;
            cfg_mode      <= MODE_2X2;
            cfg_diag_only <= 1'b0;
            sparsity_pct  <= '0;
            diag_dominant <= 1'b0;
        end else begin
            wr_en     <= 1'b0;
            scan_done <= 1'b0;
            case (state)
                SCAN_IDLE: begin
                    if (start) begin
                        cfg_dim       <= matrix_dim;
                        cfg_mode      <= partition_mode;
                        cfg_diag_only <= diag_only;
                        row           <= '0;
                        col           <= '0;
                        zeros         <= '0;
                        diag_sum      <= '0;
                        off_sum       <= '0;
                        state         <= SCAN_LOAD;
                    end
                end
                SCAN_LOAD: begin
                    if (elem_valid) begin
                        wr_en <= 1'b1;
                        zeros <= zeros_nxt;
                        if (row == col) begin
                            diag_sum <= diag_sum + SUM_W'(abs_val(elem_data));
                        end else begin
                            off_sum <= off_sum + SUM_W'(abs_val(elem_data));
                        end
                        if (col_last) begin
                            col <= '0;
                            if (row_last) begin
                                // dividend zeros * 100, divisor dim^2
                                rem   <= REM_W'(zeros_nxt * 100);
                                quot  <= '0;
                                state <= SCAN_DIV;
                            end else begin
                                row <= row + 1'b1;
                            end
                        end else begin
                            col <= col + 1'b1;
                        end
                    end
                end
                SCAN_DIV: begin
                    // one subtraction per cycle
                    if (rem >= dim_sq) begin
                        rem  <= rem - dim_sq;
                        quot <= quot + 1'b1;
                    end else begin
                        sparsity_pct  <= quot;
                        diag_dominant <= (diag_sum > off_sum);
                        scan_done     <= 1'b1;
                        state         <= SCAN_WAIT;
                    end
                end
                SCAN_WAIT: begin
                    if (emit_done) begin
                        state <= SCAN_IDLE;
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SCAN_LOAD && elem_valid) begin
            wr_addr <= ADDR_W'(row * MAX_DIM + col);
            wr_data <= elem_data;
        end
    end

endmodule

`default_nettype wire

/* verilog/block_emitter.sv */
`timescale 1ns/1ns
`default_nettype none

module block_emitter #(
    parameter int MAX_DIM    = 8,
    parameter int DATA_WIDTH = 16,
    localparam int DIM_W     = $clog2(MAX_DIM + 1),
    localparam int ADDR_W    = $clog2(MAX_DIM * MAX_DIM),
    localparam int CNT_W     = $clog2((MAX_DIM / 2) * (MAX_DIM / 2) + 1),
    localparam int BPR_W     = $clog2(MAX_DIM / 2 + 1)
) (
    input  logic                           clk,
    input  logic                           rst_n,

    // from the scanner
    input  logic                           scan_done,
    input  logic [DIM_W-1:0]               cfg_dim,
    input  mat_part_pkg::part_mode_e       cfg_mode,
    input  logic                           cfg_diag_only,
    input  logic [mat_part_pkg::PCT_W-1:0] sparsity_pct,
    input  logic                           diag_dominant,

    // buffer read port
    output logic [ADDR_W-1:0]              rd_addr,
    input  logic signed [DATA_WIDTH-1:0]   rd_data,

    // tile stream
    output logic                           block_valid,
    output logic                           block_first,
    output logic                           block_last,
    output logic signed [DATA_WIDTH-1:0]   block_data,
    output logic [CNT_W-1:0]               block_index,
    output logic [2:0]                     block_size,
    output logic                           block_diag,
    output logic                           done,
    output logic [CNT_W-1:0]               num_blocks,
    output logic [BPR_W-1:0]               blocks_per_row
);
    import mat_part_pkg::*;

    // padded positions reach past MAX_DIM for odd tile fits
    localparam int POS_W = $clog2(MAX_DIM + 4);

    emit_state_e      state;
    logic             tile4_q;
    logic [BPR_W-1:0] bpr_q;
    logic [CNT_W-1:0] nblk_q;
    logic [BPR_W-1:0] tr;
    logic [BPR_W-1:0] tc;
    logic [1:0]       er;
    logic [1:0]       ec;
    logic [CNT_W-1:0] idx;

    logic             tile4_r;
    logic [BPR_W-1:0] bpr_r;
    logic [CNT_W-1:0] nblk_r;
    logic [2:0]       tsize;
    logic [1:0]       ts_m1;
    logic [POS_W-1:0] row_abs;
    logic [POS_W-1:0] col_abs;
    logic             pad;
    logic             tile_end;
    logic             run_end;

    // data stage
    logic             v_q;
    logic             first_q;
    logic             last_q;
    logic             diag_q;
    logic             pad_q;
    logic [CNT_W-1:0] index_q;

    always_comb begin
        tile4_r = (cfg_mode == MODE_4X4) ||
                  (cfg_mode == MODE_AUTO && !diag_dominant &&
                   sparsity_pct <= AUTO_SPARSE_PCT);
        bpr_r   = tile4_r ? BPR_W'((cfg_dim + 3) >> 2) : BPR_W'((cfg_dim + 1) >> 1);
        nblk_r  = cfg_diag_only ? CNT_W'(bpr_r) : CNT_W'(bpr_r) * CNT_W'(bpr_r);
    end

    assign tsize   = tile4_q ? 3'd4 : 3'd2;
    assign ts_m1   = tile4_q ? 2'd3 : 2'd1;
    assign row_abs = POS_W'(tr) * POS_W'(tsize) + POS_W'(er);
    assign col_abs = POS_W'(tc) * POS_W'(tsize) + POS_W'(ec);
    assign pad     = (row_abs >= cfg_dim) || (col_abs >= cfg_dim);
    assign rd_addr = pad ? '0 : ADDR_W'(row_abs * MAX_DIM + col_abs);

    assign tile_end = (er == ts_m1) && (ec == ts_m1);
    assign run_end  = cfg_diag_only ? (tr == bpr_q - 1'b1) :
                      (tr == bpr_q - 1'b1) && (tc == bpr_q - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= EMIT_IDLE;
            tile4_q <= 1'b0;
            bpr_q   <= '0;
            nblk_q  <= '0;
            tr      <= '0;
            tc      <= '0;
            er      <= '0;
            ec      <= '0;
            idx     <= '0;
            v_q     <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
            diag_q  <= 1'b0;
        end else begin
            v_q     <= 1'b0;
            first_q <= 1'b0;
            last_q  <= 1'b0;
            diag_q  <= 1'b0;
            case (state)
                EMIT_IDLE: begin
                    if (scan_done) begin
                        tile4_q <= tile4_r;
                        bpr_q   <= bpr_r;
                        nblk_q  <= nblk_r;
                        tr      <= '0;
                        tc      <= '0;
                        er      <= '0;
                        ec      <= '0;
                        idx     <= '0;
                        state   <= EMIT_TILE;
                    end
                end
                EMIT_TILE: begin
                    v_q     <= 1'b1;
                    first_q <= (er == 2'd0) && (ec == 2'd0);
                    last_q  <= tile_end;
                    diag_q  <= (tr == tc);
                    if (ec == ts_m1) begin
                        ec <= '0;
                        if (er == ts_m1) begin
                            er  <= '0;
                            idx <= idx + 1'b1;
                            if (run_end) begin
                                state <= EMIT_DRAIN;
                            end else if (cfg_diag_only) begin
                                // next diagonal tile
                                tr <= tr + 1'b1;
                                tc <= tc + 1'b1;
                            end else if (tc == bpr_q - 1'b1) begin
                                tc <= '0;
                                tr <= tr + 1'b1;
                            end else begin
                                tc <= tc + 1'b1;
                            end
                        end else begin
                            er <= er + 1'b1;
                        end
                    end else begin
                        ec <= ec + 1'b1;
                    end
                end
                EMIT_DRAIN: state <= EMIT_DONE;
                EMIT_DONE:  state <= EMIT_IDLE;
                default:    state <= EMIT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == EMIT_TILE) begin
            pad_q   <= pad;
            index_q <= idx;
        end
    end

    // rd_data lines up with the data stage
    assign block_valid    = v_q;
    assign block_first    = first_q;
    assign block_last     = last_q;
    assign block_diag     = diag_q;
    assign block_index    = index_q;
    assign block_data     = pad_q ? '0 : rd_data;
    assign block_size     = tsize;
    assign done           = (state == EMIT_DONE);
    assign num_blocks     = nblk_q;
    assign blocks_per_row = bpr_q;

endmodule

`default_nettype wire

/* verilog/block_partitioner.sv */
`timescale 1ns/1ns
`default_nettype none

module block_partitioner #(
    parameter int MAX_DIM    = 8,
    parameter int DATA_WIDTH = 16,
    localparam int DIM_W     = $clog2(MAX_DIM + 1),
    localparam int ADDR_W    = $clog2(MAX_DIM * MAX_DIM),
    localparam int CNT_W     = $clog2((MAX_DIM / 2) * (MAX_DIM / 2) + 1),
    localparam int BPR_W     = $clog2(MAX_DIM / 2 + 1)
) (
    input  logic                           clk,
    input  logic                           rst_n,

    input  logic                           start,
    input  logic [DIM_W-1:0]               matrix_dim,
    input  mat_part_pkg::part_mode_e       partition_mode,
    input  logic                           diag_only,
    input  logic signed [DATA_WIDTH-1:0]   elem_data,
    input  logic                           elem_valid,

    output logic                           busy,
    output logic                           block_valid,
    output logic                           block_first,
    output logic                           block_last,
    output logic signed [DATA_WIDTH-1:0]   block_data,
    output logic [CNT_W-1:0]               block_index,
    output logic [2:0]                     block_size,
    output logic                           block_diag,
    output logic                           done,

    // stable from done until the next start
    output logic [CNT_W-1:0]               num_blocks,
    output logic [BPR_W-1:0]               blocks_per_row,
    output logic [mat_part_pkg::PCT_W-1:0] sparsity_pct,
    output logic                           diag_dominant
);
    import mat_part_pkg::*;

    logic                         wr_en;
    logic [ADDR_W-1:0]            wr_addr;
    logic signed [DATA_WIDTH-1:0] wr_data;
    logic [ADDR_W-1:0]            rd_addr;
    logic signed [DATA_WIDTH-1:0] rd_data;
    logic                         scan_done;
    logic [DIM_W-1:0]             cfg_dim;
    part_mode_e                   cfg_mode;
    logic                         cfg_diag_only;

    matrix_scanner #(
        .MAX_DIM    (MAX_DIM),
        .DATA_WIDTH (DATA_WIDTH)
    ) scanner_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .matrix_dim     (matrix_dim),
        .partition_mode (partition_mode),
        .diag_only      (diag_only),
        .elem_data      (elem_data),
        .elem_valid     (elem_valid),
        .emit_done      (done),
        .wr_en          (wr_en),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data),
        .scan_done      (scan_done),
        .cfg_dim        (cfg_dim),
        .cfg_mode       (cfg_mode),
        .cfg_diag_only  (cfg_diag_only),
        .sparsity_pct   (sparsity_pct),
        .diag_dominant  (diag_dominant),
        .busy           (busy)
    );

    matrix_buffer #(
        .MAX_DIM    (MAX_DIM),
        .DATA_WIDTH (DATA_WIDTH)
    ) buffer_i (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    block_emitter #(
        .MAX_DIM    (MAX_DIM),
        .DATA_WIDTH (DATA_WIDTH)
    ) emitter_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .scan_done      (scan_done),
        .cfg_dim        (cfg_dim),
        .cfg_mode       (cfg_mode),
        .cfg_diag_only  (cfg_diag_only),
        .sparsity_pct   (sparsity_pct),
        .diag_dominant  (diag_dominant),
        .rd_addr        (rd_addr),
        .rd_data        (rd_data),
        .block_valid    (block_valid),
        .block_first    (block_first),
        .block_last     (block_last),
        .block_data     (block_data),
        .block_index    (block_index),
        .block_size     (block_size),
        .block_diag     (block_diag),
        .done           (done),
        .num_blocks     (num_blocks),
        .blocks_per_row (blocks_per_row)
    );

endmodule

`default_nettype wire

/* tests/block_partitioner_checker.sv */
`timescale 1ns/1ns
`default_nettype none

module block_partitioner_checker (
    input logic clk,
    input logic rst_n,
    input logic busy,
    input logic block_valid,
    input logic block_first,
    input logic done
);

    // failure count, watched by the testbench
    int fail_count = 0;

    // tile beats only inside a run
    valid_in_run: assert property (@(posedge clk) disable iff (!rst_n)
        block_valid |-> busy)
    else begin
        fail_count = fail_count + 1;
        $error("block_valid seen while busy is low");
    end

    done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
    else begin
        fail_count = fail_count + 1;
        $error("done held for more than one cycle");
    end

    first_is_valid: assert property (@(posedge clk) disable iff (!rst_n)
        block_first |-> block_valid)
    else begin
        fail_count = fail_count + 1;
        $error("block_first seen without block_valid");
    end

endmodule

bind block_partitioner block_partitioner_checker checker_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .busy        (busy),
    .block_valid (block_valid),
    .block_first (block_first),
    .done        (done)
);

`default_nettype wire

/* tests/block_partitioner_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module block_partitioner_tb;
    import mat_part_pkg::*;

    localparam int MAX_DIM    = 8;
    localparam int DATA_WIDTH = 16;
    localparam int NUM_CASES  = 12;

    // matrix patterns
    localparam logic [1:0] PAT_IDENT  = 2'd0;
    localparam logic [1:0] PAT_DENSE  = 2'd1;
    localparam logic [1:0] PAT_SPARSE = 2'd2;
    localparam logic [1:0] PAT_ZERO   = 2'd3;

    typedef struct packed {
        logic [3:0] dim;
        part_mode_e mode;
        logic       diag;
        logic [1:0] pattern;
        // 0 where the pattern is random
        logic [2:0] size;
    } case_t;

    case_t cases [NUM_CASES] = '{
        '{4'd4, MODE_2X2,  1'b0, PAT_DENSE,  3'd2},
        '{4'd5, MODE_2X2,  1'b0, PAT_SPARSE, 3'd2},
        '{4'd6, MODE_4X4,  1'b0, PAT_DENSE,  3'd4},
        '{4'd8, MODE_4X4,  1'b0, PAT_IDENT,  3'd4},
        '{4'd8, MODE_AUTO, 1'b0, PAT_IDENT,  3'd2},
        '{4'd7, MODE_AUTO, 1'b0, PAT_DENSE,  3'd0},
        '{4'd6, MODE_AUTO, 1'b0, PAT_SPARSE, 3'd0},
        '{4'd5, MODE_AUTO, 1'b0, PAT_ZERO,   3'd2},
        '{4'd8, MODE_2X2,  1'b1, PAT_DENSE,  3'd2},
        '{4'd7, MODE_4X4,  1'b1, PAT_IDENT,  3'd4},
        '{4'd3, MODE_AUTO, 1'b1, PAT_ZERO,   3'd2},
        '{4'd1, MODE_2X2,  1'b0, PAT_IDENT,  3'd2}
    };

    logic                         clk;
    logic                         rst_n;
    logic                         start;
    logic [3:0]                   matrix_dim;
    part_mode_e                   partition_mode;
    logic                         diag_only;
    logic signed [DATA_WIDTH-1:0] elem_data;
    logic                         elem_valid;
    logic                         busy;
    logic                         block_valid;
    logic                         block_first;
    logic                         block_last;
    logic signed [DATA_WIDTH-1:0] block_data;
    logic [4:0]                   block_index;
    logic [2:0]                   block_size;
    logic                         block_diag;
    logic                         done;
    logic [4:0]                   num_blocks;
    logic [2:0]                   blocks_per_row;
    logic [PCT_W-1:0]             sparsity_pct;
    logic                         diag_dominant;

    int mat [MAX_DIM][MAX_DIM];

    block_partitioner #(
        .MAX_DIM    (MAX_DIM),
        .DATA_WIDTH (DATA_WIDTH)
    ) dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .start          (start),
        .matrix_dim     (matrix_dim),
        .partition_mode (partition_mode),
        .diag_only      (diag_only),
        .elem_data      (elem_data),
        .elem_valid     (elem_valid),
        .busy           (busy),
        .block_valid    (block_valid),
        .block_first    (block_first),
        .block_last     (block_last),
        .block_data     (block_data),
        .block_index    (block_index),
        .block_size     (block_size),
        .block_diag     (block_diag),
        .done           (done),
        .num_blocks     (num_blocks),
        .blocks_per_row (blocks_per_row),
        .sparsity_pct   (sparsity_pct),
        .diag_dominant  (diag_dominant)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "run stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            stop_run($sformatf("mismatch at %0t ns: %s = %0d, expected %0d",
                               $time, name, got, exp));
        end
    endtask

    function automatic int magnitude(input int v);
        return (v < 0) ? -v : v;
    endfunction

    task automatic fill_matrix(input int dim, input logic [1:0] pattern);
        logic signed [DATA_WIDTH-1:0] v16;
        for (int r = 0; r < MAX_DIM; r++) begin
            for (int c = 0; c < MAX_DIM; c++) begin
                mat[r][c] = 0;
                if (r < dim && c < dim) begin
                    case (pattern)
                        PAT_IDENT: begin
                            // strong diagonal, a few small off-diagonal terms
                            if (r == c) begin
                                mat[r][c] = 200 + 13 * r;
                            end else if ((r + c) % 3 == 0) begin
                                mat[r][c] = r - c;
                            end
                        end
                        PAT_DENSE: begin
                            v16 = DATA_WIDTH'($urandom);
                            mat[r][c] = v16;
                        end
                        PAT_SPARSE: begin
                            if ($urandom % 4 == 0) begin
                                mat[r][c] = int'($urandom % 101) - 50;
                            end
                        end
                        default: mat[r][c] = 0;
                    endcase
                end
            end
        end
    endtask

    task automatic run_case(input int k);
        case_t cfg;
        int    dim;
        int    zeros;
        int    diag_sum;
        int    off_sum;
        int    pct;
        int    ts;
        int    bpr;
        int    nblk;
        int    beat;
        int    tile_idx;
        int    r;
        int    c;
        bit    dominant;
        cfg = cases[k];
        dim = int'(cfg.dim);
        fill_matrix(dim, cfg.pattern);

        // reference model
        zeros    = 0;
        diag_sum = 0;
        off_sum  = 0;
        for (int i = 0; i < dim; i++) begin
            for (int j = 0; j < dim; j++) begin
                if (mat[i][j] == 0) zeros++;
                if (i == j) diag_sum += magnitude(mat[i][j]);
                else off_sum += magnitude(mat[i][j]);
            end
        end
        pct      = zeros * 100 / (dim * dim);
        dominant = (diag_sum > off_sum);
        if (cfg.mode == MODE_2X2) ts = 2;
        else if (cfg.mode == MODE_4X4) ts = 4;
        else ts = (dominant || pct > AUTO_SPARSE_PCT) ? 2 : 4;
        bpr  = (dim + ts - 1) / ts;
        nblk = cfg.diag ? bpr : bpr * bpr;

        @(negedge clk);
        start          = 1'b1;
        matrix_dim     = cfg.dim;
        partition_mode = cfg.mode;
        diag_only      = cfg.diag;
        @(negedge clk);
        check_value("busy", busy, 1);
        for (int i = 0; i < dim * dim; i++) begin
            if (i % 7 == 3) begin
                elem_valid = 1'b0;
                start      = 1'b0;
                @(negedge clk);
            end
            elem_valid = 1'b1;
            elem_data  = DATA_WIDTH'(mat[i / dim][i % dim]);
            // second start while busy, with a different config
            start = (i == 0);
            if (i == 0) begin
                matrix_dim = 4'(MAX_DIM);
                diag_only  = !cfg.diag;
            end
            @(negedge clk);
        end
        elem_valid = 1'b0;
        elem_data  = '0;
        start      = 1'b0;

        while (!block_valid) begin
            check_value("done", done, 0);
            @(negedge clk);
        end

        beat     = 0;
        tile_idx = 0;
        for (int tr = 0; tr < bpr; tr++) begin
            for (int tc = 0; tc < bpr; tc++) begin
                if (!cfg.diag || tr == tc) begin
                    for (int er = 0; er < ts; er++) begin
                        for (int ec = 0; ec < ts; ec++) begin
                            if (beat > 0) @(negedge clk);
                            r = tr * ts + er;
                            c = tc * ts + ec;
                            check_value("block_valid", block_valid, 1);
                            check_value("block_data", block_data,
                                        (r < dim && c < dim) ? mat[r][c] : 0);
                            check_value("block_first", block_first, er == 0 && ec == 0);
                            check_value("block_last", block_last,
                                        er == ts - 1 && ec == ts - 1);
                            check_value("block_index", block_index, tile_idx);
                            check_value("block_size", block_size, ts);
                            check_value("block_diag", block_diag, tr == tc);
                            beat++;
                        end
                    end
                    tile_idx++;
                end
            end
        end

        @(negedge clk);
        check_value("done", done, 1);
        check_value("block_valid", block_valid, 0);
        if (cfg.size != 0) check_value("block_size", block_size, int'(cfg.size));
        check_value("num_blocks", num_blocks, nblk);
        check_value("blocks_per_row", blocks_per_row, bpr);
        check_value("sparsity_pct", sparsity_pct, pct);
        check_value("diag_dominant", diag_dominant, dominant);
        @(negedge clk);
        check_value("done", done, 0);
        check_value("busy", busy, 0);
    endtask

    // limit from the table, worst case tile count per row
    initial begin
        int limit;
        int bpr_max;
        limit = 8 + 20;
        for (int k = 0; k < NUM_CASES; k++) begin
            bpr_max = (int'(cases[k].dim) + 1) / 2;
            limit += int'(cases[k].dim) * int'(cases[k].dim) + 120 + 16 * bpr_max * bpr_max;
        end
        repeat (limit) @(posedge clk);
        stop_run("watchdog expired before all cases finished");
    end

    // bound assertions count their failures
    always @(negedge clk) begin
        assert (dut_i.checker_i.fail_count == 0) else begin
            stop_run("a bound protocol assertion failed");
        end
    end

    initial begin
        void'($urandom(30831));
        rst_n          = 1'b0;
        start          = 1'b0;
        matrix_dim     = '0;
        partition_mode = MODE_2X2;
        diag_only      = 1'b0;
        elem_data      = '0;
        elem_valid     = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("busy", busy, 0);
        check_value("block_valid", block_valid, 0);
        check_value("done", done, 0);

        for (int k = 0; k < NUM_CASES; k++) begin
            run_case(k);
        end

        if (dut_i.checker_i.fail_count == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_run("a bound protocol assertion failed");
        end
    end

endmodule

`default_nettype wire

/* project.f */
verilog/mat_part_pkg.sv
verilog/matrix_buffer.sv
verilog/matrix_scanner.sv
verilog/block_emitter.sv
verilog/block_partitioner.sv
tests/block_partitioner_checker.sv
tests/block_partitioner_tb.sv

/* Bender.yml */
package:
  name: block_partitioner

sources:
  - files:
      - verilog/mat_part_pkg.sv
      - verilog/matrix_buffer.sv
      - verilog/matrix_scanner.sv
      - verilog/block_emitter.sv
      - verilog/block_partitioner.sv
  - target: test
    files:
      - tests/block_partitioner_checker.sv
      - tests/block_partitioner_tb.sv
